// File: verilog/mipsCtrlPkg.sv
package mipsCtrlPkg;

	localparam int OpWidth = 6;
	localparam int FunctWidth = 6;
	localparam int AluSelWidth = 3;

	// ALU operation select, datapath encoding
	localparam logic [AluSelWidth-1:0] AluAdd = 3'd1;
	localparam logic [AluSelWidth-1:0] AluSub = 3'd2;
	localparam logic [AluSelWidth-1:0] AluAnd = 3'd3;
	localparam logic [AluSelWidth-1:0] AluXor = 3'd6;

	typedef enum logic [OpWidth-1:0] {
		OP_RTYPE = 6'h00,	// funct field selects the operation
		OP_J = 6'h02,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_LUI = 6'h0f,
		OP_LW = 6'h23,
		OP_SW = 6'h2b
	} opCodeT;

	typedef enum logic [FunctWidth-1:0] {
		FUNCT_NOP = 6'h00,
		FUNCT_BREAK = 6'h0d,
		FUNCT_ADD = 6'h20,
		FUNCT_SUB = 6'h22,
		FUNCT_AND = 6'h24,
		FUNCT_XOR = 6'h26
	} functT;

	typedef enum logic [3:0] {
		CLASS_ADD, CLASS_AND, CLASS_SUB, CLASS_XOR, CLASS_NOP, CLASS_BREAK,
		CLASS_BEQ, CLASS_BNE, CLASS_LW, CLASS_SW, CLASS_LUI, CLASS_J,
		CLASS_ILLEGAL
	} instrClassT;

	typedef enum logic [4:0] {
		RESET, FETCH, FETCH_WAIT1, FETCH_WAIT2, DECODE,
		ALU_ADD, ALU_AND, ALU_SUB, ALU_XOR, R_WRITE, NOP,
		BRANCH_EQ, BRANCH_NE, JUMP, LUI,
		LW_ADDR, LW_READ, LW_WAIT1, LW_WAIT2, LW_WRITE,
		SW_ADDR, SW_WRITE, HALT
	} ctrlStateT;

	typedef struct packed {
		logic pcLoad;
		logic [1:0] pcSource;		// 0 alu, 1 aluOut, 2 jump target
		logic memWrite;
		logic iOrD;			// 1 selects data address
		logic irWrite;
		logic regWrite;
		logic [1:0] regDst;		// 0 rt, 1 rd
		logic [1:0] memToReg;		// 0 aluOut, 1 mdr, 2 immediate
		logic [AluSelWidth-1:0] aluSel;
		logic aluSrcA;			// 0 pc, 1 A
		logic [1:0] aluSrcB;		// 0 B, 1 four, 2 imm, 3 imm << 2
		logic aLoad;
		logic bLoad;
		logic mdrLoad;
		logic aluOutLoad;
		logic datapathReset;
	} ctrlWordT;

endpackage

// File: verilog/opDecoder.sv
`timescale 1ns/1ps

module opDecoder (
	input mipsCtrlPkg::opCodeT op,
	input mipsCtrlPkg::functT funct,
	output mipsCtrlPkg::instrClassT instrClass
);

	always_comb
	begin
		instrClass = mipsCtrlPkg::CLASS_ILLEGAL;	// anything unlisted halts
		case (op)
			mipsCtrlPkg::OP_RTYPE:
			begin
				case (funct)
					mipsCtrlPkg::FUNCT_ADD:
						instrClass = mipsCtrlPkg::CLASS_ADD;
					mipsCtrlPkg::FUNCT_AND:
						instrClass = mipsCtrlPkg::CLASS_AND;
					mipsCtrlPkg::FUNCT_SUB:
						instrClass = mipsCtrlPkg::CLASS_SUB;
					mipsCtrlPkg::FUNCT_XOR:
						instrClass = mipsCtrlPkg::CLASS_XOR;
					mipsCtrlPkg::FUNCT_NOP:
						instrClass = mipsCtrlPkg::CLASS_NOP;
					mipsCtrlPkg::FUNCT_BREAK:
						instrClass = mipsCtrlPkg::CLASS_BREAK;
					default:
						instrClass = mipsCtrlPkg::CLASS_ILLEGAL;
				endcase
			end
			mipsCtrlPkg::OP_BEQ:
				instrClass = mipsCtrlPkg::CLASS_BEQ;
			mipsCtrlPkg::OP_BNE:
				instrClass = mipsCtrlPkg::CLASS_BNE;
			mipsCtrlPkg::OP_LW:
				instrClass = mipsCtrlPkg::CLASS_LW;
			mipsCtrlPkg::OP_SW:
				instrClass = mipsCtrlPkg::CLASS_SW;
			mipsCtrlPkg::OP_LUI:
				instrClass = mipsCtrlPkg::CLASS_LUI;
			mipsCtrlPkg::OP_J:
				instrClass = mipsCtrlPkg::CLASS_J;
			default:
				instrClass = mipsCtrlPkg::CLASS_ILLEGAL;
		endcase
	end

	// an unknown class would let the sequencer wander off the decode table
	always_comb
	begin
		classKnown: assert (!$isunknown(instrClass))
			else $error("opDecoder: instrClass is unknown at %0t", $time);
	end

endmodule

// File: verilog/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::instrClassT instrClass,
	output mipsCtrlPkg::ctrlStateT state
);

	mipsCtrlPkg::ctrlStateT nextState;

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			state <= mipsCtrlPkg::RESET;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = mipsCtrlPkg::RESET;	// stray encodings restart the machine
		case (state)
			mipsCtrlPkg::RESET:
				nextState = mipsCtrlPkg::FETCH;
			mipsCtrlPkg::FETCH:
				nextState = mipsCtrlPkg::FETCH_WAIT1;
			mipsCtrlPkg::FETCH_WAIT1:
				nextState = mipsCtrlPkg::FETCH_WAIT2;	// memory latency
			mipsCtrlPkg::FETCH_WAIT2:
				nextState = mipsCtrlPkg::DECODE;
			mipsCtrlPkg::DECODE:
			begin
				// instruction register is stable here, class picks the path
				case (instrClass)
					mipsCtrlPkg::CLASS_ADD:
						nextState = mipsCtrlPkg::ALU_ADD;
					mipsCtrlPkg::CLASS_AND:
						nextState = mipsCtrlPkg::ALU_AND;
					mipsCtrlPkg::CLASS_SUB:
						nextState = mipsCtrlPkg::ALU_SUB;
					mipsCtrlPkg::CLASS_XOR:
						nextState = mipsCtrlPkg::ALU_XOR;
					mipsCtrlPkg::CLASS_NOP:
						nextState = mipsCtrlPkg::NOP;
					mipsCtrlPkg::CLASS_BEQ:
						nextState = mipsCtrlPkg::BRANCH_EQ;
					mipsCtrlPkg::CLASS_BNE:
						nextState = mipsCtrlPkg::BRANCH_NE;
					mipsCtrlPkg::CLASS_LW:
						nextState = mipsCtrlPkg::LW_ADDR;
					mipsCtrlPkg::CLASS_SW:
						nextState = mipsCtrlPkg::SW_ADDR;
					mipsCtrlPkg::CLASS_LUI:
						nextState = mipsCtrlPkg::LUI;
					mipsCtrlPkg::CLASS_J:
						nextState = mipsCtrlPkg::JUMP;
					default:
						nextState = mipsCtrlPkg::HALT;	// break and illegal
				endcase
			end
			mipsCtrlPkg::ALU_ADD,
			mipsCtrlPkg::ALU_AND,
			mipsCtrlPkg::ALU_SUB,
			mipsCtrlPkg::ALU_XOR:
				nextState = mipsCtrlPkg::R_WRITE;
			mipsCtrlPkg::R_WRITE,
			mipsCtrlPkg::NOP,
			mipsCtrlPkg::BRANCH_EQ,
			mipsCtrlPkg::BRANCH_NE,
			mipsCtrlPkg::JUMP,
			mipsCtrlPkg::LUI:
				nextState = mipsCtrlPkg::FETCH;
			mipsCtrlPkg::LW_ADDR:
				nextState = mipsCtrlPkg::LW_READ;
			mipsCtrlPkg::LW_READ:
				nextState = mipsCtrlPkg::LW_WAIT1;
			mipsCtrlPkg::LW_WAIT1:
				nextState = mipsCtrlPkg::LW_WAIT2;
			mipsCtrlPkg::LW_WAIT2:
				nextState = mipsCtrlPkg::LW_WRITE;
			mipsCtrlPkg::LW_WRITE:
				nextState = mipsCtrlPkg::FETCH;
			mipsCtrlPkg::SW_ADDR:
				nextState = mipsCtrlPkg::SW_WRITE;
			mipsCtrlPkg::SW_WRITE:
				nextState = mipsCtrlPkg::FETCH;
			mipsCtrlPkg::HALT:
				nextState = mipsCtrlPkg::HALT;	// only reset gets out
			default:
				nextState = mipsCtrlPkg::RESET;
		endcase
	end

	decodeToExecute: assert property (@(posedge Clk) disable iff (Reset_signal)
		state == mipsCtrlPkg::DECODE |=> !(state inside {mipsCtrlPkg::RESET,
			mipsCtrlPkg::FETCH, mipsCtrlPkg::FETCH_WAIT1, mipsCtrlPkg::FETCH_WAIT2,
			mipsCtrlPkg::DECODE}))
		else $error("controlFsm: DECODE not followed by an execute state at %0t", $time);

	haltHolds: assert property (@(posedge Clk) disable iff (Reset_signal)
		state == mipsCtrlPkg::HALT |=> state == mipsCtrlPkg::HALT)
		else $error("controlFsm: HALT left without reset at %0t", $time);

endmodule

// File: verilog/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen (
	input mipsCtrlPkg::ctrlStateT state,
	input logic aluZero,
	output mipsCtrlPkg::ctrlWordT ctrl
);

	mipsCtrlPkg::ctrlWordT tableWord;	// pure Moore part
	logic branchTaken;

	always_comb
	begin
		tableWord = '0;
		case (state)
			mipsCtrlPkg::RESET:
				tableWord.datapathReset = 1'b1;
			mipsCtrlPkg::FETCH,
			mipsCtrlPkg::FETCH_WAIT1:
			begin
				tableWord.aluSel = mipsCtrlPkg::AluAdd;	// pc + 4 on the alu
				tableWord.aluSrcB = 2'b01;
			end
			mipsCtrlPkg::FETCH_WAIT2:
			begin
				// memory data is ready, capture it and step the pc
				tableWord.aluSel = mipsCtrlPkg::AluAdd;
				tableWord.aluSrcB = 2'b01;
				tableWord.pcLoad = 1'b1;
				tableWord.irWrite = 1'b1;
				tableWord.mdrLoad = 1'b1;
			end
			mipsCtrlPkg::DECODE:
			begin
				tableWord.aluSel = mipsCtrlPkg::AluAdd;	// branch target
				tableWord.aluSrcB = 2'b11;
				tableWord.aLoad = 1'b1;
				tableWord.bLoad = 1'b1;
				tableWord.aluOutLoad = 1'b1;
			end
			mipsCtrlPkg::ALU_ADD,
			mipsCtrlPkg::ALU_AND,
			mipsCtrlPkg::ALU_SUB,
			mipsCtrlPkg::ALU_XOR:
			begin
				tableWord.aluSrcA = 1'b1;	// A op B
				tableWord.aluOutLoad = 1'b1;
				case (state)
					mipsCtrlPkg::ALU_AND:
						tableWord.aluSel = mipsCtrlPkg::AluAnd;
					mipsCtrlPkg::ALU_SUB:
						tableWord.aluSel = mipsCtrlPkg::AluSub;
					mipsCtrlPkg::ALU_XOR:
						tableWord.aluSel = mipsCtrlPkg::AluXor;
					default:
						tableWord.aluSel = mipsCtrlPkg::AluAdd;
				endcase
			end
			mipsCtrlPkg::R_WRITE:
			begin
				tableWord.regWrite = 1'b1;
				tableWord.regDst = 2'b01;	// rd
			end
			mipsCtrlPkg::BRANCH_EQ,
			mipsCtrlPkg::BRANCH_NE:
			begin
				tableWord.aluSel = mipsCtrlPkg::AluSub;	// compare A and B
				tableWord.aluSrcA = 1'b1;
				tableWord.pcSource = 2'b01;	// target held in aluOut
			end
			mipsCtrlPkg::JUMP:
			begin
				tableWord.pcLoad = 1'b1;
				tableWord.pcSource = 2'b10;
			end
			mipsCtrlPkg::LUI:
			begin
				tableWord.regWrite = 1'b1;
				tableWord.memToReg = 2'b10;	// upper immediate into rt
			end
			mipsCtrlPkg::LW_ADDR,
			mipsCtrlPkg::SW_ADDR:
			begin
				tableWord.aluSel = mipsCtrlPkg::AluAdd;	// base plus offset
				tableWord.aluSrcA = 1'b1;
				tableWord.aluSrcB = 2'b10;
				tableWord.aluOutLoad = 1'b1;
			end
			mipsCtrlPkg::LW_READ,
			mipsCtrlPkg::LW_WAIT1,
			mipsCtrlPkg::LW_WAIT2:
			begin
				tableWord.iOrD = 1'b1;
				tableWord.mdrLoad = 1'b1;	// keep sampling until data settles
			end
			mipsCtrlPkg::LW_WRITE:
			begin
				tableWord.regWrite = 1'b1;
				tableWord.memToReg = 2'b01;
			end
			mipsCtrlPkg::SW_WRITE:
			begin
				tableWord.memWrite = 1'b1;
				tableWord.iOrD = 1'b1;
			end
			default:
				tableWord = '0;	// NOP and HALT drive nothing
		endcase
	end

	// the only Mealy path, alu zero of the compare gates the pc
	always_comb
	begin
		branchTaken = 1'b0;
		if (state == mipsCtrlPkg::BRANCH_EQ)
			branchTaken = aluZero;
		else if (state == mipsCtrlPkg::BRANCH_NE)
			branchTaken = ~aluZero;
	end

	always_comb
	begin
		ctrl = tableWord;
		ctrl.pcLoad = tableWord.pcLoad | branchTaken;
	end

	always_comb
	begin
		noMemRegClash: assert (!(ctrl.memWrite && ctrl.regWrite))
			else $error("controlWordGen: memWrite with regWrite at %0t", $time);
		resetOnlyInReset: assert (ctrl.datapathReset == (state == mipsCtrlPkg::RESET))
			else $error("controlWordGen: datapathReset outside RESET at %0t", $time);
	end

endmodule

// File: verilog/mipsControl.sv
`timescale 1ns/1ps

module mipsControl (
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::opCodeT op,
	input mipsCtrlPkg::functT funct,
	input logic aluZero,
	output mipsCtrlPkg::ctrlWordT ctrl,
	output mipsCtrlPkg::ctrlStateT stateOut,
	output logic halted
);

	mipsCtrlPkg::instrClassT instrClass;
	mipsCtrlPkg::ctrlStateT state;

	opDecoder decoder (
		.op(op),
		.funct(funct),
		.instrClass(instrClass)
	);

	controlFsm sequencer (
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.instrClass(instrClass),
		.state(state)
	);

	controlWordGen wordGen (
		.state(state),
		.aluZero(aluZero),
		.ctrl(ctrl)
	);

	assign stateOut = state;
	assign halted = (state == mipsCtrlPkg::HALT);	// break or illegal code

endmodule

// File: verif/tbMipsControl.sv
`timescale 1ns/1ps

module tbMipsControl;

	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 10;
	localparam int Cols = 9;	// words per stimulus line
	localparam int MaxLines = 32;
	localparam int StateTimeout = 50;
	localparam int InstrTimeout = 20;
	localparam int HaltHoldCycles = 20;
	localparam logic [31:0] LfsrSeed = 32'h3b5f;

	logic Clk;
	logic Reset_signal;
	mipsCtrlPkg::opCodeT op;
	mipsCtrlPkg::functT funct;
	logic aluZero;
	mipsCtrlPkg::ctrlWordT ctrl;
	mipsCtrlPkg::ctrlStateT stateOut;
	logic halted;

	logic [7:0] stim [0:Cols*MaxLines-1];
	logic [31:0] lfsr;
	int mismatches;
	int otherFailures;
	int lineNo;
	bit timedOut;

	mipsControl DUT (
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.op(op),
		.funct(funct),
		.aluZero(aluZero),
		.ctrl(ctrl),
		.stateOut(stateOut),
		.halted(halted)
	);

	initial
	begin
		Clk = 1'b0;
		forever
			#(ClkPeriod / 2) Clk = ~Clk;
	end

	// fibonacci form, taps 32 22 2 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic int widen(input logic [7:0] v);
		return {24'd0, v};
	endfunction

	task automatic reportMismatch(input string msg);
		mismatches++;
		$display("Mismatch at %0t ns: line %0d, %s", $time, lineNo, msg);
	endtask

	task automatic waitForState(input mipsCtrlPkg::ctrlStateT target, input int limit);
		int waited;
		waited = 0;
		while (stateOut != target && !timedOut)
		begin
			@(negedge Clk);
			waited++;
			if (waited > limit)
			begin
				otherFailures++;
				timedOut = 1'b1;
				$display("Timed out waiting for state %s", target.name());
			end
		end
	endtask

	task automatic applyReset;
		mipsCtrlPkg::ctrlWordT resetWord;
		resetWord = '0;
		resetWord.datapathReset = 1'b1;	// nothing else may move in reset
		Reset_signal = 1'b1;
		repeat (ResetCycles) @(negedge Clk);
		if (stateOut != mipsCtrlPkg::RESET)
			reportMismatch($sformatf("state in reset is %s", stateOut.name()));
		if (ctrl != resetWord)
			reportMismatch($sformatf("reset control word %h, got %h", resetWord, ctrl));
		if (halted)
			reportMismatch("halted set during reset");
		Reset_signal = 1'b0;
		@(negedge Clk);
		if (stateOut != mipsCtrlPkg::FETCH)
			reportMismatch($sformatf("state after reset is %s", stateOut.name()));
	endtask

	task automatic checkControls(input mipsCtrlPkg::ctrlStateT s, input logic expPcLoad);
		logic pcWant;
		if (s inside {mipsCtrlPkg::BRANCH_EQ, mipsCtrlPkg::BRANCH_NE, mipsCtrlPkg::JUMP})
			pcWant = expPcLoad;
		else
			pcWant = (s == mipsCtrlPkg::FETCH_WAIT2);	// pc + 4 step
		if (ctrl.pcLoad != pcWant)
			reportMismatch($sformatf("pcLoad in %s expected %0b", s.name(), pcWant));
		if (ctrl.irWrite != (s == mipsCtrlPkg::FETCH_WAIT2))
			reportMismatch($sformatf("irWrite in %s is %0b", s.name(), ctrl.irWrite));
		if (ctrl.datapathReset)
			reportMismatch($sformatf("datapathReset set in %s", s.name()));
		if (halted != (s == mipsCtrlPkg::HALT))
			reportMismatch($sformatf("halted in %s is %0b", s.name(), halted));
		if (ctrl.regWrite && !(s inside {mipsCtrlPkg::R_WRITE, mipsCtrlPkg::LW_WRITE,
			mipsCtrlPkg::LUI}))
			reportMismatch($sformatf("regWrite set in %s", s.name()));
	endtask

	task automatic runInstruction(input int base);
		mipsCtrlPkg::ctrlStateT s;
		int cycles;
		int regWrites;
		int memWrites;
		int mdrLoads;
		int hold;
		logic [7:0] zeroField;
		logic [7:0] flags;
		logic [2:0] expAluSel;
		logic zeroBit;
		logic expPcLoad;
		bit done;

		cycles = 0;
		regWrites = 0;
		memWrites = 0;
		mdrLoads = 0;
		done = 1'b0;
		zeroField = stim[base + 2];
		flags = stim[base + 8];
		expAluSel = stim[base + 4][2:0];
		waitForState(mipsCtrlPkg::FETCH, StateTimeout);
		if (timedOut)
			return;

		if (zeroField == 8'h02)
		begin
			lfsr = stepLfsr(lfsr);	// one step per bit
			zeroBit = lfsr[0];
			if (stim[base][5:0] == mipsCtrlPkg::OP_BNE)
				expPcLoad = ~zeroBit;
			else
				expPcLoad = zeroBit;
		end
		else
		begin
			zeroBit = zeroField[0];
			expPcLoad = flags[1];
		end
		op = mipsCtrlPkg::opCodeT'(stim[base][5:0]);	// held until the next instruction
		funct = mipsCtrlPkg::functT'(stim[base + 1][5:0]);
		aluZero = zeroBit;

		while (!done)
		begin
			s = stateOut;
			cycles++;
			checkControls(s, expPcLoad);
			if (ctrl.regWrite)
				regWrites++;
			if (ctrl.memWrite)
				memWrites++;
			if (ctrl.mdrLoad && s != mipsCtrlPkg::FETCH_WAIT2)
				mdrLoads++;	// data reads only
			if (cycles == 5 && expAluSel != 3'd0 && ctrl.aluSel != expAluSel)
				reportMismatch($sformatf("aluSel expected %0d got %0d", expAluSel, ctrl.aluSel));
			if (s == mipsCtrlPkg::HALT)
				done = 1'b1;
			else if (cycles >= InstrTimeout)
			begin
				otherFailures++;
				timedOut = 1'b1;
				done = 1'b1;
				$display("Instruction on line %0d never returned to FETCH", lineNo);
			end
			else
			begin
				@(negedge Clk);
				if (stateOut == mipsCtrlPkg::FETCH)
					done = 1'b1;
			end
		end
		if (timedOut)
			return;

		if (cycles != widen(stim[base + 3]))
			reportMismatch($sformatf("cycles expected %0d got %0d", stim[base + 3], cycles));
		if (regWrites != widen(stim[base + 5]))
			reportMismatch($sformatf("regWrite count expected %0d got %0d",
				stim[base + 5], regWrites));
		if (memWrites != widen(stim[base + 6]))
			reportMismatch($sformatf("memWrite count expected %0d got %0d",
				stim[base + 6], memWrites));
		if (mdrLoads != widen(stim[base + 7]))
			reportMismatch($sformatf("mdrLoad count expected %0d got %0d",
				stim[base + 7], mdrLoads));
		if (flags[0] && stateOut != mipsCtrlPkg::HALT)
			reportMismatch($sformatf("HALT expected, ended in %s", stateOut.name()));
		if (!flags[0] && stateOut == mipsCtrlPkg::HALT)
			reportMismatch("unexpected HALT");

		if (stateOut == mipsCtrlPkg::HALT)
		begin
			for (hold = 0; hold < HaltHoldCycles; hold++)
			begin
				@(negedge Clk);
				if (!halted || stateOut != mipsCtrlPkg::HALT)
					reportMismatch($sformatf("halt lost after %0d cycles", hold + 1));
			end
			applyReset();	// only way out of HALT
		end
	endtask

	initial
	begin
		Reset_signal = 1'b1;
		op = mipsCtrlPkg::OP_RTYPE;
		funct = mipsCtrlPkg::FUNCT_NOP;
		aluZero = 1'b0;
		mismatches = 0;
		otherFailures = 0;
		lineNo = 0;
		timedOut = 1'b0;
		lfsr = LfsrSeed;
		$readmemh("verif/control_stimulus.txt", stim);
		if ($isunknown(stim[0]))
		begin
			otherFailures++;
			$display("Stimulus file verif/control_stimulus.txt could not be read");
		end
		else
		begin
			applyReset();
			while (lineNo < MaxLines && !timedOut && !$isunknown(stim[lineNo * Cols])
				&& stim[lineNo * Cols] != 8'hff)
			begin
				runInstruction(lineNo * Cols);
				lineNo++;
			end
		end
		$display("Error counts: %0d mismatches, %0d other failures", mismatches, otherFailures);
		if (mismatches == 0 && otherFailures == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verif/control_stimulus.txt
// op funct zero cycles aluSel regWr memWr mdrLoad flags, all hex
// zero 02 takes the LFSR bit, flags bit0 halts, bit1 pcLoad in branch or jump
00 20 00 06 01 01 00 00 00 // add
00 24 00 06 03 01 00 00 00 // and
00 22 00 06 02 01 00 00 00 // sub
00 26 00 06 06 01 00 00 00 // xor
00 00 00 05 00 00 00 00 00 // nop
04 00 01 05 00 00 00 00 02 // beq taken
04 00 00 05 00 00 00 00 00 // beq not taken
05 00 00 05 00 00 00 00 02 // bne taken
05 00 01 05 00 00 00 00 00 // bne not taken
02 00 00 05 00 00 00 00 02 // j
23 00 00 09 00 01 00 03 00 // lw
2b 00 00 06 00 00 01 00 00 // sw
0f 00 00 05 00 01 00 00 00 // lui
04 00 02 05 00 00 00 00 00 // beq, lfsr zero
05 00 02 05 00 00 00 00 00 // bne, lfsr zero
04 00 02 05 00 00 00 00 00 // beq, lfsr zero
05 00 02 05 00 00 00 00 00 // bne, lfsr zero
23 3f 00 09 00 01 00 03 00 // lw ignores funct
00 0d 00 05 00 00 00 00 01 // break
00 20 00 06 01 01 00 00 00 // add after reset
3f 00 00 05 00 00 00 00 01 // unlisted opcode
00 26 01 06 06 01 00 00 00 // xor after reset
00 07 00 05 00 00 00 00 01 // unlisted funct
2b 00 01 06 00 00 01 00 00 // sw after reset
00 00 01 05 00 00 00 00 00 // nop
ff ff ff ff ff ff ff ff ff // end of list

// File: compile.f
verilog/mipsCtrlPkg.sv
verilog/opDecoder.sv
verilog/controlFsm.sv
verilog/controlWordGen.sv
verilog/mipsControl.sv
verif/tbMipsControl.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbMipsControl -Mdir "$buildDir" -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/VtbMipsControl" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "Simulation binary returned status $runStatus"
	exit 1
fi

if grep -q "Simulation failed" "$logFile"; then
	exit 1
fi
exit 0
